// File: Makefile
# Verilator build and run of the decode control testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f flist.f --top-module tb_insn_ctrl -Mdir obj_dir

run: compile
	-./obj_dir/Vtb_insn_ctrl > sim.log 2>&1
	@cat sim.log
	@! grep -q "Finished with errors" sim.log
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: branch_decode.sv
// branch decode for id and ex
`timescale 1ns/100ps
`default_nettype none

module branch_decode
	import or1k_ctrl_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  insn_t      if_insn,
	input  wire        id_freeze,
	input  wire        flush,
	input  wire        ex_freeze,
	input  wire        ex_bubble,
	input  wire        id_void,
	input  wire        ex_branch_taken,
	output branch_op_t id_branch_op,
	output branch_op_t ex_branch_op,
	output logic       rfe,
	output logic       no_more_dslot
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_branch_op <= br_none;
		end else if (flush) begin
			id_branch_op <= br_none;
		end else if (!id_freeze) begin
			case (if_insn[31:26])
				opc_j, opc_jal:   id_branch_op <= br_j;
				opc_jr, opc_jalr: id_branch_op <= br_jr;
				opc_bnf:          id_branch_op <= br_bnf;
				opc_bf:           id_branch_op <= br_bf;
				opc_rfe:          id_branch_op <= br_rfe;
				default:          id_branch_op <= br_none;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ex_branch_op <= br_none;
		else if (ex_bubble)
			ex_branch_op <= br_none;
		else if (!ex_freeze)
			ex_branch_op <= id_branch_op;
	end

	assign rfe = (id_branch_op == br_rfe) || (ex_branch_op == br_rfe);

	// a taken branch with a real delay slot insn closes the slot
	assign no_more_dslot = ((ex_branch_op != br_none) && !id_void && ex_branch_taken)
		|| (ex_branch_op == br_rfe);

endmodule

`default_nettype wire

// File: ex_decode.sv
// ex stage instruction decode
`timescale 1ns/100ps
`default_nettype none

module ex_decode
	import or1k_ctrl_pkg::*;
(
	input  wire       clk,
	input  wire       rst_n,
	input  insn_t     id_insn,
	input  wire       ex_freeze,
	input  wire       ex_bubble,
	input  wire       du_hwbkpt,
	output alu_op_t   alu_op,
	output alu_op2_t  alu_op2,
	output comp_op_t  comp_op,
	output rfwb_op_t  rfwb_op,
	output reg_addr_t rf_addrw,
	output logic      except_illegal,
	output logic      sig_syscall,
	output logic      sig_trap
);

	opcode_t   id_opc;
	alu_op_t   alu_op_d;
	rfwb_op_t  rfwb_op_d;
	reg_addr_t rf_addrw_d;
	logic      illegal_d;
	logic      syscall_d;
	logic      trap_d;

	assign id_opc = id_insn[31:26];

	//////////////////////////////
	// next-state decode
	//////////////////////////////
	always_comb begin
		alu_op_d  = alu_nop;
		rfwb_op_d = rfwb_nop;
		illegal_d = 1'b0;
		case (id_opc)
			opc_j, opc_bnf, opc_bf, opc_rfe, opc_jr, opc_xsync, opc_nop,
			opc_sw, opc_sb, opc_sh:
				illegal_d = 1'b0;
			opc_jal, opc_jalr:
				rfwb_op_d = rfwb_link;
			opc_lwz, opc_lws, opc_lbz, opc_lbs, opc_lhz, opc_lhs:
				rfwb_op_d = rfwb_lsu;
			opc_movhi: begin
				alu_op_d  = alu_movhi;
				rfwb_op_d = rfwb_alu;
			end
			opc_addi: begin
				alu_op_d  = alu_add;
				rfwb_op_d = rfwb_alu;
			end
			opc_addic: begin
				alu_op_d  = alu_addc;
				rfwb_op_d = rfwb_alu;
			end
			opc_andi: begin
				alu_op_d  = alu_and;
				rfwb_op_d = rfwb_alu;
			end
			opc_ori: begin
				alu_op_d  = alu_or;
				rfwb_op_d = rfwb_alu;
			end
			opc_xori: begin
				alu_op_d  = alu_xor;
				rfwb_op_d = rfwb_alu;
			end
			opc_alu: begin
				alu_op_d  = {1'b0, id_insn[3:0]};
				rfwb_op_d = rfwb_alu;
				illegal_d = alu_illegal_mask[id_insn[3:0]];
			end
			opc_sfxx, opc_sfxxi:
				alu_op_d = alu_comp;
			// everything else is outside the reduced set
			default:
				illegal_d = 1'b1;
		endcase
	end

	assign rf_addrw_d = (id_opc == opc_jal || id_opc == opc_jalr) ? link_reg : id_insn[25:21];
	assign syscall_d  = (id_insn[31:23] == {opc_xsync, 3'b000});
	assign trap_d     = (id_insn[31:23] == {opc_xsync, 3'b010}) || du_hwbkpt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alu_op         <= alu_nop;
			alu_op2        <= '0;
			comp_op        <= '0;
			rfwb_op        <= rfwb_nop;
			rf_addrw       <= '0;
			except_illegal <= 1'b0;
			sig_syscall    <= 1'b0;
			sig_trap       <= 1'b0;
		end else if (ex_bubble) begin
			alu_op         <= alu_nop;
			alu_op2        <= '0;
			comp_op        <= '0;
			rfwb_op        <= rfwb_nop;
			rf_addrw       <= '0;
			except_illegal <= 1'b0;
			sig_syscall    <= 1'b0;
			sig_trap       <= 1'b0;
		end else if (!ex_freeze) begin
			alu_op         <= alu_op_d;
			alu_op2        <= id_insn[9:6];
			comp_op        <= id_insn[24:21];
			rfwb_op        <= rfwb_op_d;
			rf_addrw       <= rf_addrw_d;
			except_illegal <= illegal_d;
			sig_syscall    <= syscall_d;
			sig_trap       <= trap_d;
		end
	end

	// a jump-and-link always writes the link register
	a_link_addrw: assert property (@(posedge clk) disable iff (!rst_n)
		(rfwb_op == rfwb_link) |-> (rf_addrw == link_reg))
	else $error("link write-back without the link register");

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
or1k_ctrl_pkg.sv
insn_pipe.sv
ex_decode.sv
imm_extend.sv
branch_decode.sv
operand_select.sv
insn_ctrl.sv
tb_insn_ctrl.sv

// File: imm_extend.sv
// immediate extension and branch target
`timescale 1ns/100ps
`default_nettype none

module imm_extend
	import or1k_ctrl_pkg::*;
(
	input  wire     clk,
	input  wire     rst_n,
	input  insn_t   id_insn,
	input  word_t   id_pc,
	input  wire     ex_freeze,
	output word_t   id_simm,
	output word_t   ex_simm,
	output target_t id_branch_addrtarget,
	output target_t ex_branch_addrtarget
);

	//////////////////////////////
	// id stage, combinational
	//////////////////////////////
	always_comb begin
		case (id_insn[31:26])
			opc_addi,
			opc_addic,
			opc_lwz,
			opc_lws,
			opc_lbz,
			opc_lbs,
			opc_lhz,
			opc_lhs,
			opc_xori,
			opc_sfxxi:
				id_simm = {{16{id_insn[15]}}, id_insn[15:0]};
			// store offset is split around the rB field
			opc_sw,
			opc_sb,
			opc_sh:
				id_simm = {{16{id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			default:
				id_simm = {16'h0000, id_insn[15:0]};
		endcase
	end

	// word offset, sign extended to 30 bits
	assign id_branch_addrtarget = {{4{id_insn[25]}}, id_insn[25:0]} + id_pc[31:2];

	//////////////////////////////
	// ex stage copies
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_simm              <= '0;
			ex_branch_addrtarget <= '0;
		end else if (!ex_freeze) begin
			ex_simm              <= id_simm;
			ex_branch_addrtarget <= id_branch_addrtarget;
		end
	end

endmodule

`default_nettype wire

// File: insn_ctrl.sv
// instruction decode control, top level
`timescale 1ns/100ps
`default_nettype none

module insn_ctrl
	import or1k_ctrl_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  insn_t      if_insn,
	input  word_t      id_pc,
	input  wire        id_freeze,
	input  wire        ex_freeze,
	input  wire        wb_freeze,
	input  wire        flush,
	input  wire        ex_branch_taken,
	input  wire        wbforw_valid,
	input  wire        du_hwbkpt,
	output insn_t      id_insn,
	output insn_t      ex_insn,
	output insn_t      wb_insn,
	output logic       id_void,
	output logic       ex_void,
	output logic       ex_bubble,
	output alu_op_t    alu_op,
	output alu_op2_t   alu_op2,
	output comp_op_t   comp_op,
	output rfwb_op_t   rfwb_op,
	output reg_addr_t  rf_addrw,
	output logic       except_illegal,
	output logic       sig_syscall,
	output logic       sig_trap,
	output word_t      id_simm,
	output word_t      ex_simm,
	output target_t    id_branch_addrtarget,
	output target_t    ex_branch_addrtarget,
	output branch_op_t id_branch_op,
	output branch_op_t ex_branch_op,
	output logic       rfe,
	output logic       no_more_dslot,
	output sel_t       sel_a,
	output sel_t       sel_b,
	output lsu_op_t    id_lsu_op
);

	// bubble is formed once, in the latches
	insn_pipe u_insn_pipe (.clk, .rst_n, .if_insn, .id_freeze, .ex_freeze, .wb_freeze,
		.flush, .id_insn, .ex_insn, .wb_insn, .id_void, .ex_void, .ex_bubble);

	ex_decode u_ex_decode (.clk, .rst_n, .id_insn, .ex_freeze, .ex_bubble, .du_hwbkpt,
		.alu_op, .alu_op2, .comp_op, .rfwb_op, .rf_addrw, .except_illegal,
		.sig_syscall, .sig_trap);

	imm_extend u_imm_extend (.clk, .rst_n, .id_insn, .id_pc, .ex_freeze, .id_simm,
		.ex_simm, .id_branch_addrtarget, .ex_branch_addrtarget);

	branch_decode u_branch_decode (.clk, .rst_n, .if_insn, .id_freeze, .flush,
		.ex_freeze, .ex_bubble, .id_void, .ex_branch_taken, .id_branch_op,
		.ex_branch_op, .rfe, .no_more_dslot);

	// ex write address feeds the forward compare
	operand_select u_operand_select (.clk, .rst_n, .if_insn, .id_insn, .id_freeze,
		.wb_freeze, .rf_addrw, .rfwb_op, .wbforw_valid, .sel_a, .sel_b, .id_lsu_op);

endmodule

`default_nettype wire

// File: insn_pipe.sv
// instruction latches
`timescale 1ns/100ps
`default_nettype none

module insn_pipe
	import or1k_ctrl_pkg::*;
(
	input  wire   clk,
	input  wire   rst_n,
	input  insn_t if_insn,
	input  wire   id_freeze,
	input  wire   ex_freeze,
	input  wire   wb_freeze,
	input  wire   flush,
	output insn_t id_insn,
	output insn_t ex_insn,
	output insn_t wb_insn,
	output logic  id_void,
	output logic  ex_void,
	output logic  ex_bubble
);

	// EX moves on while ID holds or is flushed
	assign ex_bubble = !ex_freeze && (id_freeze || flush);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_insn <= nop_insn;
			ex_insn <= nop_insn;
			wb_insn <= nop_insn;
		end else begin
			if (flush)
				id_insn <= nop_insn;
			else if (!id_freeze)
				id_insn <= if_insn;

			if (ex_bubble)
				ex_insn <= nop_insn;
			else if (!ex_freeze)
				ex_insn <= id_insn;

			// wb only ever stalls
			if (!wb_freeze)
				wb_insn <= ex_insn;
		end
	end

	assign id_void = (id_insn[31:26] == opc_nop) && id_insn[16];
	assign ex_void = (ex_insn[31:26] == opc_nop) && ex_insn[16];

	// the bubble word must read as a void slot for the branch logic
	a_ex_bubble_void: assert property (@(posedge clk) disable iff (!rst_n)
		ex_bubble |=> ex_void)
	else $error("bubble in ex is not a void slot");

endmodule

`default_nettype wire

// File: operand_select.sv
// operand source selection
`timescale 1ns/100ps
`default_nettype none

module operand_select
	import or1k_ctrl_pkg::*;
(
	input  wire       clk,
	input  wire       rst_n,
	input  insn_t     if_insn,
	input  insn_t     id_insn,
	input  wire       id_freeze,
	input  wire       wb_freeze,
	input  reg_addr_t rf_addrw,
	input  rfwb_op_t  rfwb_op,
	input  wire       wbforw_valid,
	output sel_t      sel_a,
	output sel_t      sel_b,
	output lsu_op_t   id_lsu_op
);

	logic      sel_imm;
	reg_addr_t wb_rf_addrw;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_imm <= 1'b0;
		end else if (!id_freeze) begin
			case (if_insn[31:26])
				opc_jalr, opc_jr, opc_rfe, opc_xsync, opc_sw, opc_sb, opc_sh,
				opc_alu, opc_sfxx, opc_nop:
					sel_imm <= 1'b0;
				default:
					sel_imm <= 1'b1;
			endcase
		end
	end

	// wb copy of the write address, for the second forward path
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_rf_addrw <= '0;
		else if (!wb_freeze)
			wb_rf_addrw <= rf_addrw;
	end

	//////////////////////////////
	// forwarding priority
	//////////////////////////////
	always_comb begin
		if ((id_insn[20:16] == rf_addrw) && rfwb_op[0])
			sel_a = sel_src_ex;
		else if ((id_insn[20:16] == wb_rf_addrw) && wbforw_valid)
			sel_a = sel_src_wb;
		else
			sel_a = sel_src_rf;

		if (sel_imm)
			sel_b = sel_src_imm;
		else if ((id_insn[15:11] == rf_addrw) && rfwb_op[0])
			sel_b = sel_src_ex;
		else if ((id_insn[15:11] == wb_rf_addrw) && wbforw_valid)
			sel_b = sel_src_wb;
		else
			sel_b = sel_src_rf;
	end

	always_comb begin
		case (id_insn[31:26])
			opc_lwz: id_lsu_op = lsu_lwz;
			opc_lws: id_lsu_op = lsu_lws;
			opc_lbz: id_lsu_op = lsu_lbz;
			opc_lbs: id_lsu_op = lsu_lbs;
			opc_lhz: id_lsu_op = lsu_lhz;
			opc_lhs: id_lsu_op = lsu_lhs;
			opc_sw:  id_lsu_op = lsu_sw;
			opc_sb:  id_lsu_op = lsu_sb;
			opc_sh:  id_lsu_op = lsu_sh;
			default: id_lsu_op = lsu_nop;
		endcase
	end

	a_addi_sel_imm: assert property (@(posedge clk) disable iff (!rst_n)
		(!id_freeze && if_insn[31:26] == opc_addi) |=> (sel_b == sel_src_imm))
	else $error("sel_b is not the immediate after addi");

endmodule

`default_nettype wire

// File: or1k_ctrl_pkg.sv
// decode control package
`default_nettype none

package or1k_ctrl_pkg;

	//////////////////////////////
	// widths that carry a meaning
	//////////////////////////////
	typedef logic [31:0] insn_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [29:0] target_t;
	typedef logic [4:0]  alu_op_t;
	typedef logic [3:0]  alu_op2_t;
	typedef logic [3:0]  comp_op_t;
	typedef logic [3:0]  rfwb_op_t;
	typedef logic [2:0]  branch_op_t;
	typedef logic [3:0]  lsu_op_t;
	typedef logic [1:0]  sel_t;

	//////////////////////////////
	// major opcodes, bits 31:26
	//////////////////////////////
	localparam opcode_t opc_j     = 6'h00;
	localparam opcode_t opc_jal   = 6'h01;
	localparam opcode_t opc_bnf   = 6'h03;
	localparam opcode_t opc_bf    = 6'h04;
	localparam opcode_t opc_nop   = 6'h05;
	localparam opcode_t opc_movhi = 6'h06;
	localparam opcode_t opc_xsync = 6'h08;
	localparam opcode_t opc_rfe   = 6'h09;
	localparam opcode_t opc_jr    = 6'h11;
	localparam opcode_t opc_jalr  = 6'h12;
	// loads
	localparam opcode_t opc_lwz   = 6'h21;
	localparam opcode_t opc_lws   = 6'h22;
	localparam opcode_t opc_lbz   = 6'h23;
	localparam opcode_t opc_lbs   = 6'h24;
	localparam opcode_t opc_lhz   = 6'h25;
	localparam opcode_t opc_lhs   = 6'h26;
	// alu with immediate
	localparam opcode_t opc_addi  = 6'h27;
	localparam opcode_t opc_addic = 6'h28;
	localparam opcode_t opc_andi  = 6'h29;
	localparam opcode_t opc_ori   = 6'h2a;
	localparam opcode_t opc_xori  = 6'h2b;
	localparam opcode_t opc_sfxxi = 6'h2f;
	// stores
	localparam opcode_t opc_sw    = 6'h35;
	localparam opcode_t opc_sb    = 6'h36;
	localparam opcode_t opc_sh    = 6'h37;
	localparam opcode_t opc_alu   = 6'h38;
	localparam opcode_t opc_sfxx  = 6'h39;

	//////////////////////////////
	// alu codes
	//////////////////////////////
	localparam alu_op_t alu_add   = 5'd0;
	localparam alu_op_t alu_addc  = 5'd1;
	localparam alu_op_t alu_and   = 5'd3;
	localparam alu_op_t alu_or    = 5'd4;
	localparam alu_op_t alu_xor   = 5'd5;
	localparam alu_op_t alu_movhi = 5'd14;
	localparam alu_op_t alu_nop   = 5'd15;
	localparam alu_op_t alu_comp  = 5'd16;
	// sub-ops 6, 9..13 and 15 are not in this core
	localparam logic [15:0] alu_illegal_mask = 16'hbe40;

	// write-back: source in [3:1], enable in [0]
	localparam rfwb_op_t rfwb_nop  = 4'b000_0;
	localparam rfwb_op_t rfwb_alu  = 4'b000_1;
	localparam rfwb_op_t rfwb_lsu  = 4'b001_1;
	localparam rfwb_op_t rfwb_link = 4'b011_1;

	localparam branch_op_t br_none = 3'd0;
	localparam branch_op_t br_j    = 3'd1;
	localparam branch_op_t br_jr   = 3'd2;
	localparam branch_op_t br_bnf  = 3'd3;
	localparam branch_op_t br_bf   = 3'd4;
	localparam branch_op_t br_rfe  = 3'd6;

	localparam lsu_op_t lsu_nop = 4'b0000;
	localparam lsu_op_t lsu_lbz = 4'b0010;
	localparam lsu_op_t lsu_lbs = 4'b0011;
	localparam lsu_op_t lsu_lhz = 4'b0100;
	localparam lsu_op_t lsu_lhs = 4'b0101;
	localparam lsu_op_t lsu_lwz = 4'b0110;
	localparam lsu_op_t lsu_lws = 4'b0111;
	localparam lsu_op_t lsu_sb  = 4'b1010;
	localparam lsu_op_t lsu_sh  = 4'b1100;
	localparam lsu_op_t lsu_sw  = 4'b1110;

	localparam sel_t sel_src_rf  = 2'd0;
	localparam sel_t sel_src_imm = 2'd1;
	localparam sel_t sel_src_ex  = 2'd2;
	localparam sel_t sel_src_wb  = 2'd3;

	localparam reg_addr_t link_reg = 5'd9;
	// nop with bit 16 set, marks a void slot
	localparam insn_t nop_insn = 32'h1441_0000;

endpackage

`default_nettype wire

// File: tb_ref_model.svh
// reference decode model
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic is_load(input opcode_t opc);
	return opc inside {opc_lwz, opc_lws, opc_lbz, opc_lbs, opc_lhz, opc_lhs};
endfunction

function automatic logic is_store(input opcode_t opc);
	return opc inside {opc_sw, opc_sb, opc_sh};
endfunction

function automatic logic is_imm_alu(input opcode_t opc);
	return opc inside {opc_addi, opc_addic, opc_andi, opc_ori, opc_xori};
endfunction

// opcodes that the reduced core still decodes
function automatic logic is_kept(input opcode_t opc);
	return is_load(opc) || is_store(opc) || is_imm_alu(opc)
		|| (opc inside {opc_j, opc_jal, opc_bnf, opc_bf, opc_nop, opc_movhi, opc_xsync,
		opc_rfe, opc_jr, opc_jalr, opc_sfxxi, opc_alu, opc_sfxx});
endfunction

function automatic alu_op_t ref_alu_op(input insn_t insn);
	alu_op_t op;
	case (insn[31:26])
		opc_movhi: op = alu_movhi;
		opc_addi:  op = alu_add;
		opc_addic: op = alu_addc;
		opc_andi:  op = alu_and;
		opc_ori:   op = alu_or;
		opc_xori:  op = alu_xor;
		opc_alu:   op = {1'b0, insn[3:0]};
		opc_sfxx,
		opc_sfxxi: op = alu_comp;
		default:   op = alu_nop;
	endcase
	return op;
endfunction

function automatic rfwb_op_t ref_rfwb(input insn_t insn);
	opcode_t opc;
	opc = insn[31:26];
	if (opc == opc_jal || opc == opc_jalr)
		return rfwb_link;
	else if (is_load(opc))
		return rfwb_lsu;
	else if (is_imm_alu(opc) || opc == opc_movhi || opc == opc_alu)
		return rfwb_alu;
	else
		return rfwb_nop;
endfunction

function automatic reg_addr_t ref_addrw(input insn_t insn);
	return (insn[31:26] inside {opc_jal, opc_jalr}) ? link_reg : insn[25:21];
endfunction

function automatic logic ref_illegal(input insn_t insn);
	logic [3:0] sub;
	sub = insn[3:0];
	// alu sub-ops that the reduced core leaves out
	return !is_kept(insn[31:26]) || ((insn[31:26] == opc_alu)
		&& (sub inside {4'd6, 4'd9, 4'd10, 4'd11, 4'd12, 4'd13, 4'd15}));
endfunction

function automatic logic ref_syscall(input insn_t insn);
	return insn[31:23] == {opc_xsync, 3'b000};
endfunction

function automatic logic ref_trap(input insn_t insn, input logic hwbkpt);
	return (insn[31:23] == {opc_xsync, 3'b010}) || hwbkpt;
endfunction

function automatic word_t ref_simm(input insn_t insn);
	opcode_t opc;
	opc = insn[31:26];
	if (is_load(opc) || (opc inside {opc_addi, opc_addic, opc_xori, opc_sfxxi}))
		return {{16{insn[15]}}, insn[15:0]};
	else if (is_store(opc))
		return {{16{insn[25]}}, insn[25:21], insn[10:0]};
	else
		return {16'h0000, insn[15:0]};
endfunction

function automatic target_t ref_target(input insn_t insn, input word_t pc);
	target_t offset;
	offset = {{4{insn[25]}}, insn[25:0]};
	return offset + pc[31:2];
endfunction

function automatic branch_op_t ref_branch_op(input insn_t insn);
	branch_op_t op;
	case (insn[31:26])
		opc_j, opc_jal:   op = br_j;
		opc_jr, opc_jalr: op = br_jr;
		opc_bnf:          op = br_bnf;
		opc_bf:           op = br_bf;
		opc_rfe:          op = br_rfe;
		default:          op = br_none;
	endcase
	return op;
endfunction

function automatic logic ref_sel_imm(input insn_t insn);
	return !(insn[31:26] inside {opc_jalr, opc_jr, opc_rfe, opc_xsync, opc_sw, opc_sb,
		opc_sh, opc_alu, opc_sfxx, opc_nop});
endfunction

// immediate first, then ex forward, then wb forward
function automatic sel_t ref_sel(input reg_addr_t src, input logic use_imm,
	input reg_addr_t ex_addr, input logic ex_we, input reg_addr_t wb_addr,
	input logic wb_valid);
	if (use_imm)
		return sel_src_imm;
	else if (src == ex_addr && ex_we)
		return sel_src_ex;
	else if (src == wb_addr && wb_valid)
		return sel_src_wb;
	else
		return sel_src_rf;
endfunction

function automatic lsu_op_t ref_lsu_op(input insn_t insn);
	lsu_op_t op;
	case (insn[31:26])
		opc_lwz: op = lsu_lwz;
		opc_lws: op = lsu_lws;
		opc_lbz: op = lsu_lbz;
		opc_lbs: op = lsu_lbs;
		opc_lhz: op = lsu_lhz;
		opc_lhs: op = lsu_lhs;
		opc_sw:  op = lsu_sw;
		opc_sb:  op = lsu_sb;
		opc_sh:  op = lsu_sh;
		default: op = lsu_nop;
	endcase
	return op;
endfunction

`endif

// File: tb_insn_ctrl.sv
// testbench for the decode control
`timescale 1ns/100ps
`default_nettype none

module tb_insn_ctrl
	import or1k_ctrl_pkg::*;
();

	logic       clk;
	logic       rst_n;
	insn_t      if_insn;
	word_t      id_pc;
	logic       id_freeze, ex_freeze, wb_freeze, flush;
	logic       ex_branch_taken, wbforw_valid, du_hwbkpt;
	insn_t      id_insn, ex_insn, wb_insn;
	logic       id_void, ex_void, ex_bubble;
	alu_op_t    alu_op;
	alu_op2_t   alu_op2;
	comp_op_t   comp_op;
	rfwb_op_t   rfwb_op;
	reg_addr_t  rf_addrw;
	logic       except_illegal, sig_syscall, sig_trap;
	word_t      id_simm, ex_simm;
	target_t    id_branch_addrtarget, ex_branch_addrtarget;
	branch_op_t id_branch_op, ex_branch_op;
	logic       rfe, no_more_dslot;
	sel_t       sel_a, sel_b;
	lsu_op_t    id_lsu_op;

	// expected pipeline contents
	insn_t      exp_id_insn, exp_ex_insn, exp_wb_insn;
	alu_op_t    exp_alu_op;
	alu_op2_t   exp_alu_op2;
	comp_op_t   exp_comp_op;
	rfwb_op_t   exp_rfwb;
	reg_addr_t  exp_addrw, exp_wb_addrw;
	logic       exp_illegal, exp_syscall, exp_trap;
	word_t      exp_ex_simm;
	target_t    exp_ex_target;
	branch_op_t exp_id_br, exp_ex_br;
	logic       exp_sel_imm;

	logic [31:0] rng_state;
	insn_t       prev_insn, prev2_insn;
	logic        checking;

	`include "tb_ref_model.svh"

	insn_ctrl UUT (.*);

	initial begin : clock_gen
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin : reset_gen
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

	//////////////////////////////
	// reporting and compare tasks
	//////////////////////////////
	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_target(input string name, input target_t got, input target_t exp);
		if (got !== exp)
			fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_alu_op(input string name, input alu_op_t got, input alu_op_t exp);
		if (got !== exp)
			fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_field(input string name, input alu_op2_t got, input alu_op2_t exp);
		if (got !== exp)
			fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_comp_op(input string name, input comp_op_t got, input comp_op_t exp);
		if (got !== exp)
			fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_lsu_op(input string name, input lsu_op_t got, input lsu_op_t exp);
		if (got !== exp)
			fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_rfwb(input string name, input rfwb_op_t got, input rfwb_op_t exp);
		if (got !== exp)
			fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp)
			fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_branch(input string name, input branch_op_t got,
		input branch_op_t exp);
		if (got !== exp)
			fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_sel(input string name, input sel_t got, input sel_t exp);
		if (got !== exp)
			fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_reset_state();
		check_word("id_insn", id_insn, nop_insn);
		check_word("ex_insn", ex_insn, nop_insn);
		check_word("wb_insn", wb_insn, nop_insn);
		check_alu_op("alu_op", alu_op, alu_nop);
		check_rfwb("rfwb_op", rfwb_op, rfwb_nop);
		check_branch("id_branch_op", id_branch_op, br_none);
		check_branch("ex_branch_op", ex_branch_op, br_none);
		check_flag("except_illegal", except_illegal, 1'b0);
		check_flag("sig_syscall", sig_syscall, 1'b0);
		check_flag("sig_trap", sig_trap, 1'b0);
		check_flag("rfe", rfe, 1'b0);
		check_flag("no_more_dslot", no_more_dslot, 1'b0);
		check_sel("sel_a", sel_a, sel_src_rf);
		check_sel("sel_b", sel_b, sel_src_rf);
	endtask

	//////////////////////////////
	// shadow pipeline
	//////////////////////////////
	task automatic clear_ex_shadow();
		exp_ex_insn = nop_insn;
		exp_alu_op  = alu_nop;
		exp_alu_op2 = '0;
		exp_comp_op = '0;
		exp_rfwb    = rfwb_nop;
		exp_addrw   = '0;
		exp_illegal = 1'b0;
		exp_syscall = 1'b0;
		exp_trap    = 1'b0;
		exp_ex_br   = br_none;
	endtask

	always @(posedge clk) begin : shadow
		logic bubble;
		bubble = !ex_freeze && (id_freeze || flush);
		if (!rst_n) begin
			clear_ex_shadow();
			exp_id_insn   = nop_insn;
			exp_wb_insn   = nop_insn;
			exp_wb_addrw  = '0;
			exp_ex_simm   = '0;
			exp_ex_target = '0;
			exp_id_br     = br_none;
			exp_sel_imm   = 1'b0;
		end else begin
			// wb first, it takes the old ex values
			if (!wb_freeze) begin
				exp_wb_insn  = exp_ex_insn;
				exp_wb_addrw = exp_addrw;
			end
			if (bubble) begin
				clear_ex_shadow();
			end else if (!ex_freeze) begin
				exp_ex_insn = exp_id_insn;
				exp_alu_op  = ref_alu_op(exp_id_insn);
				exp_alu_op2 = exp_id_insn[9:6];
				exp_comp_op = exp_id_insn[24:21];
				exp_rfwb    = ref_rfwb(exp_id_insn);
				exp_addrw   = ref_addrw(exp_id_insn);
				exp_illegal = ref_illegal(exp_id_insn);
				exp_syscall = ref_syscall(exp_id_insn);
				exp_trap    = ref_trap(exp_id_insn, du_hwbkpt);
				exp_ex_br   = exp_id_br;
			end
			// immediates ignore the bubble
			if (!ex_freeze) begin
				exp_ex_simm   = ref_simm(exp_id_insn);
				exp_ex_target = ref_target(exp_id_insn, id_pc);
			end
			if (flush) begin
				exp_id_insn = nop_insn;
				exp_id_br   = br_none;
			end else if (!id_freeze) begin
				exp_id_insn = if_insn;
				exp_id_br   = ref_branch_op(if_insn);
			end
			if (!id_freeze)
				exp_sel_imm = ref_sel_imm(if_insn);
		end
	end

	task automatic compare_outputs();
		logic id_void_exp;
		logic ex_void_exp;
		logic dslot_exp;
		id_void_exp = (exp_id_insn[31:26] == opc_nop) && exp_id_insn[16];
		ex_void_exp = (exp_ex_insn[31:26] == opc_nop) && exp_ex_insn[16];
		dslot_exp = ((exp_ex_br != br_none) && !id_void_exp && ex_branch_taken)
			|| (exp_ex_br == br_rfe);
		check_word("id_insn", id_insn, exp_id_insn);
		check_word("ex_insn", ex_insn, exp_ex_insn);
		check_word("wb_insn", wb_insn, exp_wb_insn);
		check_flag("id_void", id_void, id_void_exp);
		check_flag("ex_void", ex_void, ex_void_exp);
		check_flag("ex_bubble", ex_bubble, !ex_freeze && (id_freeze || flush));
		check_alu_op("alu_op", alu_op, exp_alu_op);
		check_field("alu_op2", alu_op2, exp_alu_op2);
		check_comp_op("comp_op", comp_op, exp_comp_op);
		check_rfwb("rfwb_op", rfwb_op, exp_rfwb);
		check_addr("rf_addrw", rf_addrw, exp_addrw);
		check_flag("except_illegal", except_illegal, exp_illegal);
		check_flag("sig_syscall", sig_syscall, exp_syscall);
		check_flag("sig_trap", sig_trap, exp_trap);
		check_word("id_simm", id_simm, ref_simm(exp_id_insn));
		check_word("ex_simm", ex_simm, exp_ex_simm);
		check_target("id_branch_addrtarget", id_branch_addrtarget,
			ref_target(exp_id_insn, id_pc));
		check_target("ex_branch_addrtarget", ex_branch_addrtarget, exp_ex_target);
		check_branch("id_branch_op", id_branch_op, exp_id_br);
		check_branch("ex_branch_op", ex_branch_op, exp_ex_br);
		check_flag("rfe", rfe, (exp_id_br == br_rfe) || (exp_ex_br == br_rfe));
		check_flag("no_more_dslot", no_more_dslot, dslot_exp);
		check_sel("sel_a", sel_a, ref_sel(exp_id_insn[20:16], 1'b0, exp_addrw, exp_rfwb[0],
			exp_wb_addrw, wbforw_valid));
		check_sel("sel_b", sel_b, ref_sel(exp_id_insn[15:11], exp_sel_imm, exp_addrw,
			exp_rfwb[0], exp_wb_addrw, wbforw_valid));
		check_lsu_op("id_lsu_op", id_lsu_op, ref_lsu_op(exp_id_insn));
	endtask

	// outputs are stable half a cycle after the drive
	always @(negedge clk) begin
		if (checking)
			compare_outputs();
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	task automatic make_insn(output insn_t w);
		logic [31:0] r;
		logic [31:0] s;
		next_rand(r);
		next_rand(s);
		w = r;
		// mostly kept opcodes, a few stay random
		if (s[3:0] != 4'h0) begin
			for (int i = 0; i < 16 && !is_kept(w[31:26]); i++) begin
				next_rand(r);
				w[31:26] = r[31:26];
			end
		end
		// reuse recent write fields so both forward paths hit
		if (s[4])
			w[20:16] = s[5] ? prev_insn[25:21] : prev2_insn[25:21];
		if (s[6])
			w[15:11] = s[7] ? prev_insn[25:21] : link_reg;
		if (w[31:26] == opc_xsync && s[8])
			w[25:23] = {1'b0, s[9], 1'b0};
		prev2_insn = prev_insn;
		prev_insn = w;
	endtask

	task automatic drive_cycle(input logic stalls);
		logic [31:0] r;
		@(posedge clk);
		#1;
		make_insn(if_insn);
		next_rand(id_pc);
		next_rand(r);
		ex_branch_taken = r[0];
		wbforw_valid    = r[1];
		du_hwbkpt       = (r[6:2] == 5'd0);
		flush           = stalls && (r[9:7] == 3'd0);
		id_freeze       = stalls && (r[11:10] == 2'd0);
		ex_freeze       = stalls && (r[14:12] == 3'd0);
		wb_freeze       = stalls && (r[17:15] == 3'd0);
	endtask

	initial begin : main
		int wait_cycles;
		if_insn         = nop_insn;
		id_pc           = '0;
		id_freeze       = 1'b0;
		ex_freeze       = 1'b0;
		wb_freeze       = 1'b0;
		flush           = 1'b0;
		ex_branch_taken = 1'b0;
		wbforw_valid    = 1'b0;
		du_hwbkpt       = 1'b0;
		checking        = 1'b0;
		rng_state       = 32'd62;
		prev_insn       = nop_insn;
		prev2_insn      = nop_insn;
		wait_cycles     = 0;
		while (rst_n !== 1'b1) begin
			@(negedge clk);
			wait_cycles++;
			if (wait_cycles > 32)
				fail_now("reset was never released");
		end
		check_reset_state();
		checking = 1'b1;
		// free-running decode, then freeze and flush mixed in
		repeat (400) drive_cycle(1'b0);
		repeat (600) drive_cycle(1'b1);
		repeat (2) @(negedge clk);
		#1;
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire
